//--- vlog.f
design/i3c_tgt_pkg.sv
design/i3c_bus_sampler.sv
design/i3c_byte_shifter.sv
design/enthdr_tgt_ctrl.sv
design/i3c_enthdr_tgt.sv
tb/tb_i3c_enthdr_tgt.sv

//--- Bender.yml
package:
  name: i3c_enthdr_tgt

sources:
  - files:
      - design/i3c_tgt_pkg.sv
      - design/i3c_bus_sampler.sv
      - design/i3c_byte_shifter.sv
      - design/enthdr_tgt_ctrl.sv
      - design/i3c_enthdr_tgt.sv
  - target: test
    files:
      - tb/tb_i3c_enthdr_tgt.sv

//--- tb/tb_i3c_enthdr_tgt.sv
module tb_i3c_enthdr_tgt;

	import i3c_tgt_pkg::*;

	// bus timing in system clocks.
	localparam int HALF = 8;
	localparam int QTR  = 4;

	localparam int DONE_TIMEOUT = 40;

	logic i_sys_clk;
	logic i_sys_rst;
	logic i_engine_en;
	logic i_scl;
	logic i_sda;
	logic sda_drv;
	logic o_sda_pull_low;
	logic o_engine_done;

	logic [15:0] lfsr_q;
	int          done_cnt = 0;
	int          pull_cnt = 0;

	// open-drain SDA, either side can pull it low.
	assign i_sda = sda_drv & ~o_sda_pull_low;

	i3c_enthdr_tgt DUT (
		.i_sys_clk      (i_sys_clk),
		.i_sys_rst      (i_sys_rst),
		.i_engine_en    (i_engine_en),
		.i_scl          (i_scl),
		.i_sda          (i_sda),
		.o_sda_pull_low (o_sda_pull_low),
		.o_engine_done  (o_engine_done)
	);

	initial
	begin
		i_sys_clk = 1'b0;
		forever #2 i_sys_clk = ~i_sys_clk;
	end

	// counts done pulses and pull-low cycles.
	always @(negedge i_sys_clk)
	begin
		if (o_engine_done)
			done_cnt++;
		if (o_sda_pull_low)
			pull_cnt++;
	end

	// ==================================================
	// helpers
	// ==================================================

	// taps 16, 14, 13, 11.
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	// T-bit that makes the count of ones odd over command and T-bit.
	function automatic logic odd_parity_bit(input byte_t b);
		int ones;
		int i;
		ones = 0;
		for (i = 0; i < 8; i++)
			ones += b[i];
		return (ones % 2 == 0);
	endfunction

	task automatic rand_byte(output byte_t b);
		int i;
		b = '0;
		for (i = 0; i < 8; i++)
		begin
			lfsr_q = lfsr_next(lfsr_q);
			b = {b[6:0], lfsr_q[0]};
		end
	endtask

	task automatic check(input logic [31:0] exp, input logic [31:0] act, input string msg);
		if (exp !== act)
		begin
			$display("FAILED at %0t: %s, expected %0h, got %0h", $time, msg, exp, act);
			$display("Verification failed");
			$fatal(1, "mismatch");
		end
	endtask

	task automatic fail_timeout(input string what);
		$display("ERROR: gave up waiting for %s at time %0t", what, $time);
		$display("Verification failed");
		$fatal(1, "timeout");
	endtask

	task automatic hold(input int n);
		repeat (n) @(negedge i_sys_clk);
	endtask

	task automatic wait_done(input int base);
		int n;
		n = 0;
		while (done_cnt == base && n < DONE_TIMEOUT)
		begin
			hold(1);
			n++;
		end
		if (done_cnt == base)
			fail_timeout("o_engine_done");
	endtask

	// ==================================================
	// bus model
	// ==================================================

	// also serves as repeated START when SCL is low.
	task automatic bus_start();
		sda_drv = 1'b1;
		hold(QTR);
		i_scl = 1'b1;
		hold(QTR);
		sda_drv = 1'b0;
		hold(QTR);
		i_scl = 1'b0;
		hold(QTR);
	endtask

	task automatic bus_stop();
		sda_drv = 1'b0;
		hold(QTR);
		i_scl = 1'b1;
		hold(QTR);
		sda_drv = 1'b1;
		hold(HALF);
	endtask

	task automatic bus_bit(input logic b);
		sda_drv = b;
		hold(QTR);
		i_scl = 1'b1;
		hold(HALF);
		i_scl = 1'b0;
		hold(QTR);
	endtask

	task automatic bus_byte(input byte_t b);
		int i;
		for (i = 7; i >= 0; i--)
			bus_bit(b[i]);
	endtask

	task automatic bus_ack(output logic acked);
		sda_drv = 1'b1;
		hold(QTR);
		i_scl = 1'b1;
		hold(HALF);
		acked = o_sda_pull_low;
		i_scl = 1'b0;
		hold(QTR);
	endtask

	// START, address, ACK, command, T-bit, STOP.
	task automatic run_sequence(input byte_t addr, input byte_t cmd, input logic tbit,
		input logic exp_ack, input logic exp_done, input string msg);
		int   done_base;
		int   pull_base;
		logic acked;
		done_base = done_cnt;
		pull_base = pull_cnt;
		bus_start();
		bus_byte(addr);
		bus_ack(acked);
		check(exp_ack, acked, {msg, ": ack"});
		bus_byte(cmd);
		bus_bit(tbit);
		if (exp_done)
			wait_done(done_base);
		bus_stop();
		check(exp_done, done_cnt - done_base, {msg, ": done pulses"});
		if (!exp_ack)
			check(0, pull_cnt - pull_base, {msg, ": pull-low cycles"});
	endtask

	// ==================================================
	// tests
	// ==================================================

	task automatic test_reset_entry();
		check(0, o_sda_pull_low, "pull-low after reset");
		check(0, o_engine_done, "done after reset");
		run_sequence({BCAST_ADDR, 1'b0}, ENTHDR0_CCC, odd_parity_bit(ENTHDR0_CCC),
			1'b1, 1'b1, "entry");
	endtask

	task automatic test_addr_mismatch();
		byte_t a;
		int    k;
		run_sequence(8'hFD, ENTHDR0_CCC, odd_parity_bit(ENTHDR0_CCC), 1'b0, 1'b0, "read bit");
		for (k = 0; k < 9; k++)
		begin
			rand_byte(a);
			while (a == {BCAST_ADDR, 1'b0})
				rand_byte(a);
			run_sequence(a, ENTHDR0_CCC, odd_parity_bit(ENTHDR0_CCC), 1'b0, 1'b0,
				$sformatf("address %0h", a));
		end
	endtask

	task automatic test_cmd_mismatch();
		run_sequence({BCAST_ADDR, 1'b0}, 8'h21, odd_parity_bit(8'h21), 1'b1, 1'b0, "cmd 21");
		run_sequence({BCAST_ADDR, 1'b0}, 8'hFF, odd_parity_bit(8'hFF), 1'b1, 1'b0, "cmd ff");
	endtask

	task automatic test_bad_tbit();
		run_sequence({BCAST_ADDR, 1'b0}, ENTHDR0_CCC, ~odd_parity_bit(ENTHDR0_CCC),
			1'b1, 1'b0, "bad t-bit");
		run_sequence({BCAST_ADDR, 1'b0}, ENTHDR0_CCC, odd_parity_bit(ENTHDR0_CCC),
			1'b1, 1'b1, "entry after bad t-bit");
	endtask

	task automatic test_engine_off();
		i_engine_en = 1'b0;
		run_sequence({BCAST_ADDR, 1'b0}, ENTHDR0_CCC, odd_parity_bit(ENTHDR0_CCC),
			1'b0, 1'b0, "engine off");
		i_engine_en = 1'b1;
		hold(HALF);
	endtask

	task automatic test_abort();
		int   done_base;
		logic acked;
		int   i;
		// repeated START inside the address byte.
		bus_start();
		for (i = 7; i >= 4; i--)
			bus_bit(BCAST_ADDR[i-1]);
		run_sequence({BCAST_ADDR, 1'b0}, ENTHDR0_CCC, odd_parity_bit(ENTHDR0_CCC),
			1'b1, 1'b1, "repeated start");
		// STOP inside the command byte.
		done_base = done_cnt;
		bus_start();
		bus_byte({BCAST_ADDR, 1'b0});
		bus_ack(acked);
		check(1, acked, "stop abort: ack");
		for (i = 7; i >= 4; i--)
			bus_bit(ENTHDR0_CCC[i]);
		bus_stop();
		// the rest of the command and its T-bit still clock in after the STOP.
		i_scl = 1'b0;
		hold(QTR);
		for (i = 3; i >= 0; i--)
			bus_bit(ENTHDR0_CCC[i]);
		bus_bit(odd_parity_bit(ENTHDR0_CCC));
		bus_stop();
		hold(HALF);
		check(0, done_cnt - done_base, "stop abort: done pulses");
	endtask

	initial
	begin
		i_sys_rst   = 1'b0;
		i_engine_en = 1'b1;
		i_scl       = 1'b1;
		sda_drv     = 1'b1;
		lfsr_q      = 16'd42;
		hold(3);
		i_sys_rst = 1'b1;
		hold(2);

		test_reset_entry();
		test_addr_mismatch();
		test_cmd_mismatch();
		test_bad_tbit();
		test_engine_off();
		test_abort();

		$display("Verification passed");
		$finish;
	end

endmodule

//--- design/i3c_enthdr_tgt.sv
module i3c_enthdr_tgt (
	input  logic i_sys_clk,
	input  logic i_sys_rst,
	input  logic i_engine_en,
	input  logic i_scl,
	input  logic i_sda,
	output logic o_sda_pull_low,
	output logic o_engine_done
);

	import i3c_tgt_pkg::*;

	bus_evt_t bus_evt;
	byte_t    rx_byte;
	logic     byte_done;
	logic     shift_clear;

	// line sampling and event detect.
	i3c_bus_sampler u_sampler (
		.i_sys_clk (i_sys_clk),
		.i_sys_rst (i_sys_rst),
		.i_scl     (i_scl),
		.i_sda     (i_sda),
		.o_evt     (bus_evt)
	);

	// serial to byte.
	i3c_byte_shifter u_shifter (
		.i_sys_clk   (i_sys_clk),
		.i_sys_rst   (i_sys_rst),
		.i_evt       (bus_evt),
		.i_clear     (shift_clear),
		.o_byte      (rx_byte),
		.o_byte_done (byte_done)
	);

	// address, ACK, command and T-bit sequencing.
	enthdr_tgt_ctrl u_ctrl (
		.i_sys_clk      (i_sys_clk),
		.i_sys_rst      (i_sys_rst),
		.i_engine_en    (i_engine_en),
		.i_evt          (bus_evt),
		.i_byte         (rx_byte),
		.i_byte_done    (byte_done),
		.o_shift_clear  (shift_clear),
		.o_sda_pull_low (o_sda_pull_low),
		.o_engine_done  (o_engine_done)
	);

endmodule

//--- design/enthdr_tgt_ctrl.sv
module enthdr_tgt_ctrl (
	input  logic                  i_sys_clk,
	input  logic                  i_sys_rst,
	input  logic                  i_engine_en,
	input  i3c_tgt_pkg::bus_evt_t i_evt,
	input  i3c_tgt_pkg::byte_t    i_byte,
	input  logic                  i_byte_done,
	output logic                  o_shift_clear,
	output logic                  o_sda_pull_low,
	output logic                  o_engine_done
);

	import i3c_tgt_pkg::*;

	tgt_state_e state;

	// command byte captured at the end of CMD.
	byte_t cmd_q;

	logic addr_match;
	logic cmd_match;
	logic tbit_ok;

	// address byte is the broadcast address followed by a write bit.
	assign addr_match = (i_byte == {BCAST_ADDR, 1'b0});

	assign cmd_match = (cmd_q == ENTHDR0_CCC);

	// T-bit gives odd parity over the command.
	assign tbit_ok = (i_evt.sda == ~^cmd_q);

	// ==================================================
	// entry FSM
	// ==================================================

	always_ff @(posedge i_sys_clk or negedge i_sys_rst)
	begin
		if (!i_sys_rst)
		begin
			state          <= IDLE;
			o_sda_pull_low <= 1'b0;
			o_shift_clear  <= 1'b0;
			o_engine_done  <= 1'b0;
		end
		else
		begin
			o_shift_clear <= 1'b0;
			o_engine_done <= 1'b0;

			if (!i_engine_en)
			begin
				// disabled engine holds the bus released.
				state          <= IDLE;
				o_sda_pull_low <= 1'b0;
			end
			else if (i_evt.start)
			begin
				// START or repeated START, the shifter clears itself.
				state          <= ADDR;
				o_sda_pull_low <= 1'b0;
			end
			else if (i_evt.stop)
			begin
				state          <= IDLE;
				o_sda_pull_low <= 1'b0;
			end
			else
			begin
				case (state)
					IDLE:
					begin
						state <= IDLE;
					end

					ADDR:
					begin
						if (i_byte_done)
						begin
							if (addr_match)
								state <= ACK_WAIT;
							else
								state <= IDLE;
						end
					end

					// drive the ACK once SCL drops after bit eight.
					ACK_WAIT:
					begin
						if (i_evt.scl_fall)
						begin
							o_sda_pull_low <= 1'b1;
							state          <= ACK;
						end
					end

					ACK:
					begin
						if (i_evt.scl_fall)
						begin
							o_sda_pull_low <= 1'b0;
							o_shift_clear  <= 1'b1;
							state          <= CMD;
						end
					end

					CMD:
					begin
						if (i_byte_done)
							state <= TBIT;
					end

					TBIT:
					begin
						if (i_evt.scl_rise)
						begin
							o_engine_done <= cmd_match & tbit_ok;
							state         <= IDLE;
						end
					end

					default:
					begin
						state          <= IDLE;
						o_sda_pull_low <= 1'b0;
					end
				endcase
			end
		end
	end

	// command capture.
	always_ff @(posedge i_sys_clk)
	begin
		if ((state == CMD) && i_byte_done)
			cmd_q <= i_byte;
	end

endmodule

//--- design/i3c_byte_shifter.sv
module i3c_byte_shifter (
	input  logic                  i_sys_clk,
	input  logic                  i_sys_rst,
	input  i3c_tgt_pkg::bus_evt_t i_evt,
	input  logic                  i_clear,
	output i3c_tgt_pkg::byte_t    o_byte,
	output logic                  o_byte_done
);

	import i3c_tgt_pkg::*;

	logic [BIT_CNT_W-1:0] bit_cnt;
	logic [BIT_CNT_W-1:0] bit_cnt_nxt;
	byte_t                shift_q;

	assign bit_cnt_nxt = bit_cnt + 1'b1;

	// bit counter and done strobe.
	always_ff @(posedge i_sys_clk or negedge i_sys_rst)
	begin
		if (!i_sys_rst)
		begin
			bit_cnt     <= '0;
			o_byte_done <= 1'b0;
		end
		else
		begin
			o_byte_done <= 1'b0;
			if (i_clear || i_evt.start)
				bit_cnt <= '0;
			else if (i_evt.scl_rise)
			begin
				if (bit_cnt_nxt == BYTE_BITS)
				begin
					bit_cnt     <= '0;
					o_byte_done <= 1'b1;
				end
				else
					bit_cnt <= bit_cnt_nxt;
			end
		end
	end

	// data shifts in MSB first.
	always_ff @(posedge i_sys_clk)
	begin
		if (i_evt.scl_rise)
			shift_q <= {shift_q[6:0], i_evt.sda};
	end

	assign o_byte = shift_q;

endmodule

//--- design/i3c_bus_sampler.sv
module i3c_bus_sampler (
	input  logic                  i_sys_clk,
	input  logic                  i_sys_rst,
	input  logic                  i_scl,
	input  logic                  i_sda,
	output i3c_tgt_pkg::bus_evt_t o_evt
);

	import i3c_tgt_pkg::*;

	// two flop synchronizers, index 1 is the settled level.
	logic [1:0] scl_sync;
	logic [1:0] sda_sync;

	// synchronized levels from the previous cycle.
	logic scl_prev;
	logic sda_prev;

	// registered event strobes.
	logic scl_rise_q;
	logic scl_fall_q;
	logic start_q;
	logic stop_q;

	// ==================================================
	// synchronizers
	// ==================================================

	// idle bus level is high on both lines.
	always_ff @(posedge i_sys_clk or negedge i_sys_rst)
	begin
		if (!i_sys_rst)
		begin
			scl_sync <= 2'b11;
			sda_sync <= 2'b11;
			scl_prev <= 1'b1;
			sda_prev <= 1'b1;
		end
		else
		begin
			scl_sync <= {scl_sync[0], i_scl};
			sda_sync <= {sda_sync[0], i_sda};
			scl_prev <= scl_sync[1];
			sda_prev <= sda_sync[1];
		end
	end

	// ==================================================
	// edge and condition detect
	// ==================================================

	// START and STOP need SCL high in both the old and new sample.
	always_ff @(posedge i_sys_clk or negedge i_sys_rst)
	begin
		if (!i_sys_rst)
		begin
			scl_rise_q <= 1'b0;
			scl_fall_q <= 1'b0;
			start_q    <= 1'b0;
			stop_q     <= 1'b0;
		end
		else
		begin
			scl_rise_q <= scl_sync[1] & ~scl_prev;
			scl_fall_q <= ~scl_sync[1] & scl_prev;
			start_q    <= scl_sync[1] & scl_prev & sda_prev & ~sda_sync[1];
			stop_q     <= scl_sync[1] & scl_prev & ~sda_prev & sda_sync[1];
		end
	end

	assign o_evt = '{
		scl_rise: scl_rise_q,
		scl_fall: scl_fall_q,
		start:    start_q,
		stop:     stop_q,
		sda:      sda_sync[1]
	};

endmodule

//--- design/i3c_tgt_pkg.sv
package i3c_tgt_pkg;

	// ==================================================
	// bus constants
	// ==================================================

	// broadcast address, sent with the write bit.
	localparam logic [6:0] BCAST_ADDR = 7'h7E;

	// broadcast command for HDR-DDR entry.
	localparam logic [7:0] ENTHDR0_CCC = 8'h20;

	// bit counter width and the number of data bits in one byte.
	localparam int BIT_CNT_W = 4;
	localparam logic [BIT_CNT_W-1:0] BYTE_BITS = 4'd8;

	// ==================================================
	// shared types
	// ==================================================

	typedef logic [7:0] byte_t;

	// bus events for one system clock cycle.
	typedef struct packed {
		logic scl_rise;
		logic scl_fall;
		logic start;
		logic stop;
		logic sda;
	} bus_evt_t;

	// target entry FSM states.
	typedef enum logic [2:0] {
		IDLE     = 3'd0,
		ADDR     = 3'd1,
		ACK_WAIT = 3'd2,
		ACK      = 3'd3,
		CMD      = 3'd4,
		TBIT     = 3'd5
	} tgt_state_e;

endpackage
